// File: hdl/tc_size_pkg.sv
package tc_size_pkg;

    localparam int TILE_N = 4;
    localparam int ELEM_W = 8;
    localparam int ACC_W  = 32;
    localparam int BEAT_W = 32;
    localparam int ADDR_W = 32;

    // Skew fill plus drain of the 4x4 grid
    localparam int COMPUTE_STEPS = 3 * TILE_N - 2;

    typedef logic signed [ELEM_W-1:0] elem_t;
    typedef logic signed [ACC_W-1:0]  acc_t;
    typedef logic        [BEAT_W-1:0] beat_t;
    typedef logic        [ADDR_W-1:0] addr_t;
    typedef logic        [3:0]        burst_len_t; // Beats minus one
    typedef logic        [3:0]        beat_idx_t;
    typedef logic        [1:0]        idx_t;

    // One row per beat for A and B, one element per beat for C
    localparam burst_len_t BURST_LEN_A = 4'd3;
    localparam burst_len_t BURST_LEN_B = 4'd3;
    localparam burst_len_t BURST_LEN_C = 4'd15;

    localparam addr_t BASE_C = 32'h0001_0000;
    localparam addr_t BASE_A = 32'h0010_0000;
    localparam addr_t BASE_B = 32'h0100_0000;

endpackage

// File: hdl/tc_ctrl_pkg.sv
package tc_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        READ_C,
        LOAD_A,
        LOAD_B,
        COMPUTE,
        DONE
    } seq_state_t;

    // One-hot select codes seen on the request bus
    typedef enum logic [2:0] {
        MAT_C = 3'b001,
        MAT_A = 3'b100,
        MAT_B = 3'b010
    } mat_sel_t;

    typedef logic [3:0] step_t;

endpackage

// File: hdl/tile_sequencer.sv
`timescale 1ns/1ps

module tile_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic                    arready,
    input  logic                    burst_done,
    output logic                    req_valid,
    output tc_ctrl_pkg::mat_sel_t   req_sel,
    output tc_size_pkg::addr_t      req_base,
    output tc_size_pkg::burst_len_t req_len,
    output tc_ctrl_pkg::mat_sel_t   cur_sel,
    output logic                    compute_en,
    output tc_ctrl_pkg::step_t      step,
    output logic                    done
);
    import tc_size_pkg::*;
    import tc_ctrl_pkg::*;

    localparam step_t LAST_STEP = step_t'(COMPUTE_STEPS - 1);

    seq_state_t state;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= IDLE;
            req_valid <= 1'b0;
            step      <= '0;
        end else begin
            if (req_valid && arready) begin
                req_valid <= 1'b0; // Address phase accepted
            end
            case (state)
                IDLE, DONE: begin
                    if (start) begin
                        state     <= READ_C;
                        req_valid <= 1'b1;
                    end
                end
                READ_C: begin
                    if (burst_done) begin
                        state     <= LOAD_A;
                        req_valid <= 1'b1;
                    end
                end
                LOAD_A: begin
                    if (burst_done) begin
                        state     <= LOAD_B;
                        req_valid <= 1'b1;
                    end
                end
                LOAD_B: begin
                    if (burst_done) begin
                        state <= COMPUTE;
                        step  <= '0;
                    end
                end
                COMPUTE: begin
                    if (step == LAST_STEP) begin
                        state <= DONE;
                        step  <= '0;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Request fields follow the phase, so they hold under back-pressure
    always_comb begin
        case (state)
            READ_C: begin
                cur_sel  = MAT_C;
                req_base = BASE_C;
                req_len  = BURST_LEN_C;
            end
            LOAD_A: begin
                cur_sel  = MAT_A;
                req_base = BASE_A;
                req_len  = BURST_LEN_A;
            end
            LOAD_B: begin
                cur_sel  = MAT_B;
                req_base = BASE_B;
                req_len  = BURST_LEN_B;
            end
            default: begin
                cur_sel  = MAT_C;
                req_base = '0;
                req_len  = '0;
            end
        endcase
    end

    assign req_sel    = cur_sel;
    assign compute_en = (state == COMPUTE);
    assign done       = (state == DONE);

    a_no_req_outside_load: assert property (@(posedge clk) disable iff (!rst)
        (state inside {IDLE, COMPUTE, DONE}) |-> !req_valid);

    a_req_hold: assert property (@(posedge clk) disable iff (!rst)
        req_valid && !arready |=> req_valid && $stable(req_sel)
            && $stable(req_base) && $stable(req_len));

endmodule

// File: hdl/beat_unpacker.sv
`timescale 1ns/1ps

module beat_unpacker (
    input  logic                                           clk,
    input  logic                                           rst,
    input  tc_ctrl_pkg::mat_sel_t                          cur_sel,
    input  logic                                           beat_valid,
    input  tc_size_pkg::beat_idx_t                         beat_idx,
    input  tc_size_pkg::beat_t                             beat_data,
    output logic                                           a_we,
    output logic                                           b_we,
    output tc_size_pkg::idx_t                              wr_row,
    output tc_size_pkg::elem_t [tc_size_pkg::TILE_N-1:0]   wr_data,
    output logic                                           c_we,
    output tc_size_pkg::idx_t                              c_row,
    output tc_size_pkg::idx_t                              c_col,
    output tc_size_pkg::acc_t                              c_data
);
    import tc_size_pkg::*;
    import tc_ctrl_pkg::*;

    localparam int IDX_W = $bits(idx_t);

    beat_idx_t  idx_q;
    beat_t      data_q;
    burst_len_t max_idx;

    always_ff @(posedge clk) begin
        if (!rst) begin
            a_we <= 1'b0;
            b_we <= 1'b0;
            c_we <= 1'b0;
        end else begin
            a_we <= beat_valid && (cur_sel == MAT_A);
            b_we <= beat_valid && (cur_sel == MAT_B);
            c_we <= beat_valid && (cur_sel == MAT_C);
        end
    end

    always_ff @(posedge clk) begin
        if (beat_valid) begin
            idx_q  <= beat_idx;
            data_q <= beat_data;
        end
    end

    assign wr_row = idx_q[IDX_W-1:0];
    assign c_col  = idx_q[IDX_W-1:0]; // C is row major, four words per row
    assign c_row  = idx_q[2*IDX_W-1:IDX_W];
    assign c_data = data_q;

    for (genvar k = 0; k < TILE_N; k++) begin : g_byte
        assign wr_data[k] = data_q[k*ELEM_W +: ELEM_W]; // Byte k is column k
    end

    always_comb begin
        case (cur_sel)
            MAT_A:   max_idx = BURST_LEN_A;
            MAT_B:   max_idx = BURST_LEN_B;
            default: max_idx = BURST_LEN_C;
        endcase
    end

    a_beat_in_burst: assert property (@(posedge clk) disable iff (!rst)
        beat_valid |-> beat_idx <= max_idx);

endmodule

// File: hdl/operand_buffer.sv
`timescale 1ns/1ps

module operand_buffer #(
    parameter bit COLUMN_MAJOR = 1'b0
) (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         we,
    input  tc_size_pkg::idx_t                            wr_row,
    input  tc_size_pkg::elem_t [tc_size_pkg::TILE_N-1:0] wr_data,
    input  logic                                         compute_en,
    input  tc_ctrl_pkg::step_t                           step,
    output tc_size_pkg::elem_t [tc_size_pkg::TILE_N-1:0] lane
);
    import tc_size_pkg::*;
    import tc_ctrl_pkg::*;

    elem_t mem [TILE_N][TILE_N];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int r = 0; r < TILE_N; r++) begin
                for (int c = 0; c < TILE_N; c++) begin
                    mem[r][c] <= '0;
                end
            end
        end else if (we) begin
            for (int c = 0; c < TILE_N; c++) begin
                mem[wr_row][c] <= wr_data[c];
            end
        end
    end

    // Skewed edge feed, lane i lags lane 0 by i steps
    always_comb begin
        int k;
        k = 0;
        for (int i = 0; i < TILE_N; i++) begin
            k       = int'(step) - i;
            lane[i] = '0;
            if (compute_en && k >= 0 && k < TILE_N) begin
                if (COLUMN_MAJOR) begin
                    lane[i] = mem[idx_t'(k)][i]; // B walks down column i
                end else begin
                    lane[i] = mem[i][idx_t'(k)];
                end
            end
        end
    end

endmodule

// File: hdl/systolic_array.sv
`timescale 1ns/1ps

module systolic_array (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         compute_en,
    input  tc_size_pkg::elem_t [tc_size_pkg::TILE_N-1:0] a_lane,
    input  tc_size_pkg::elem_t [tc_size_pkg::TILE_N-1:0] b_lane,
    input  logic                                         c_we,
    input  tc_size_pkg::idx_t                            c_row,
    input  tc_size_pkg::idx_t                            c_col,
    input  tc_size_pkg::acc_t                            c_data,
    input  tc_size_pkg::idx_t                            rd_row,
    input  tc_size_pkg::idx_t                            rd_col,
    output tc_size_pkg::acc_t                            rd_data
);
    import tc_size_pkg::*;

    elem_t a_out   [TILE_N][TILE_N];
    elem_t b_out   [TILE_N][TILE_N];
    acc_t  acc_out [TILE_N][TILE_N];

    for (genvar i = 0; i < TILE_N; i++) begin : g_row
        for (genvar j = 0; j < TILE_N; j++) begin : g_col
            elem_t a_in;
            elem_t b_in;
            elem_t a_q;
            elem_t b_q;
            acc_t  acc_q;
            logic  pre;

            if (j == 0) begin : g_a_edge
                assign a_in = a_lane[i];
            end else begin : g_a_inner
                assign a_in = a_out[i][j-1]; // From left neighbour
            end

            if (i == 0) begin : g_b_edge
                assign b_in = b_lane[j];
            end else begin : g_b_inner
                assign b_in = b_out[i-1][j]; // From cell above
            end

            assign pre = c_we && (c_row == idx_t'(i)) && (c_col == idx_t'(j));

            // Flow or hold, all registers of the cell together
            always_ff @(posedge clk) begin
                if (!rst) begin
                    a_q <= '0;
                    b_q <= '0;
                end else if (pre) begin
                    a_q <= '0;
                    b_q <= '0;
                end else if (compute_en) begin
                    a_q <= a_in;
                    b_q <= b_in;
                end
            end

            always_ff @(posedge clk) begin
                if (pre) begin
                    acc_q <= c_data;
                end else if (compute_en) begin
                    acc_q <= acc_q + acc_t'(a_in) * acc_t'(b_in); // INT32 wrap
                end
            end

            assign a_out[i][j]   = a_q;
            assign b_out[i][j]   = b_q;
            assign acc_out[i][j] = acc_q;
        end
    end

    assign rd_data = acc_out[rd_row][rd_col];

    a_no_preload_in_compute: assert property (@(posedge clk) disable iff (!rst)
        !(c_we && compute_en));

endmodule

// File: hdl/tensor_core.sv
`timescale 1ns/1ps

module tensor_core (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    output logic                    req_valid,
    output tc_ctrl_pkg::mat_sel_t   req_sel,
    output tc_size_pkg::addr_t      req_base,
    output tc_size_pkg::burst_len_t req_len,
    input  logic                    arready,
    input  logic                    beat_valid,
    input  tc_size_pkg::beat_idx_t  beat_idx,
    input  tc_size_pkg::beat_t      beat_data,
    input  logic                    burst_done,
    output logic                    done,
    input  tc_size_pkg::idx_t       rd_row,
    input  tc_size_pkg::idx_t       rd_col,
    output tc_size_pkg::acc_t       rd_data
);
    import tc_size_pkg::*;
    import tc_ctrl_pkg::*;

    mat_sel_t                cur_sel;
    logic                    compute_en;
    step_t                   step;
    logic                    a_we;
    logic                    b_we;
    idx_t                    wr_row;
    elem_t [TILE_N-1:0]      wr_data;
    logic                    c_we;
    idx_t                    c_row;
    idx_t                    c_col;
    acc_t                    c_data;
    elem_t [TILE_N-1:0]      a_lane;
    elem_t [TILE_N-1:0]      b_lane;

    tile_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .arready    (arready),
        .burst_done (burst_done),
        .req_valid  (req_valid),
        .req_sel    (req_sel),
        .req_base   (req_base),
        .req_len    (req_len),
        .cur_sel    (cur_sel),
        .compute_en (compute_en),
        .step       (step),
        .done       (done)
    );

    beat_unpacker u_unpack (
        .clk        (clk),
        .rst        (rst),
        .cur_sel    (cur_sel),
        .beat_valid (beat_valid),
        .beat_idx   (beat_idx),
        .beat_data  (beat_data),
        .a_we       (a_we),
        .b_we       (b_we),
        .wr_row     (wr_row),
        .wr_data    (wr_data),
        .c_we       (c_we),
        .c_row      (c_row),
        .c_col      (c_col),
        .c_data     (c_data)
    );

    operand_buffer #(.COLUMN_MAJOR(1'b0)) buf_a (
        .clk        (clk),
        .rst        (rst),
        .we         (a_we),
        .wr_row     (wr_row),
        .wr_data    (wr_data),
        .compute_en (compute_en),
        .step       (step),
        .lane       (a_lane)
    );

    operand_buffer #(.COLUMN_MAJOR(1'b1)) buf_b (
        .clk        (clk),
        .rst        (rst),
        .we         (b_we),
        .wr_row     (wr_row),
        .wr_data    (wr_data),
        .compute_en (compute_en),
        .step       (step),
        .lane       (b_lane)
    );

    systolic_array u_array (
        .clk        (clk),
        .rst        (rst),
        .compute_en (compute_en),
        .a_lane     (a_lane),
        .b_lane     (b_lane),
        .c_we       (c_we),
        .c_row      (c_row),
        .c_col      (c_col),
        .c_data     (c_data),
        .rd_row     (rd_row),
        .rd_col     (rd_col),
        .rd_data    (rd_data)
    );

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    initial begin
        rst = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b1; // Released on a falling edge
    end

endmodule

// File: dv/tensor_core_tb.sv
`timescale 1ns/1ps

module tensor_core_tb;
    import tc_size_pkg::*;
    import tc_ctrl_pkg::*;

    localparam int REQ_WAIT_MAX = 5; // Back-pressure, accept and loop cycle
    localparam int BEAT_SLOT_MAX = 3;
    localparam int C_BURST = REQ_WAIT_MAX + TILE_N * TILE_N * BEAT_SLOT_MAX + 4;
    localparam int AB_BURST = REQ_WAIT_MAX + TILE_N * BEAT_SLOT_MAX + 4;
    localparam int JOB_CYCLES = C_BURST + 2 * AB_BURST + COMPUTE_STEPS + 2 * TILE_N * TILE_N;
    localparam int TIMEOUT = 3 * JOB_CYCLES + 100;

    logic clk, rst;
    logic start, arready, beat_valid, burst_done;
    beat_idx_t beat_idx;
    beat_t beat_data;
    idx_t rd_row, rd_col;
    logic req_valid, done;
    mat_sel_t req_sel;
    addr_t req_base;
    burst_len_t req_len;
    acc_t rd_data;

    elem_t mat_a [TILE_N][TILE_N];
    elem_t mat_b [TILE_N][TILE_N];
    acc_t mat_c [TILE_N][TILE_N];
    int seed;
    int req_total, burst_total, done_total;
    int result_errors, protocol_errors, cycle_count;
    logic done_q;
    mat_sel_t exp_sel;
    addr_t exp_base;
    burst_len_t exp_len;

    tb_clock_gen u_clk (.clk(clk), .rst(rst));

    tensor_core uut (.*);

    always @(posedge clk) begin
        if (!rst) begin
            req_total   <= 0;
            burst_total <= 0;
            done_total  <= 0;
            done_q      <= 1'b0;
        end else begin
            if (req_valid && arready) req_total <= req_total + 1;
            if (burst_done) burst_total <= burst_total + 1;
            if (done && !done_q) done_total <= done_total + 1;
            done_q <= done;
        end
    end

    // Requests of a job come in C, A, B order
    always_comb begin
        case (req_total % 3)
            0: begin
                exp_sel  = MAT_C;
                exp_base = BASE_C;
                exp_len  = BURST_LEN_C;
            end
            1: begin
                exp_sel  = MAT_A;
                exp_base = BASE_A;
                exp_len  = BURST_LEN_A;
            end
            default: begin
                exp_sel  = MAT_B;
                exp_base = BASE_B;
                exp_len  = BURST_LEN_B;
            end
        endcase
    end

    task automatic flag_protocol_error(input string what);
        protocol_errors++;
        $display("ERROR: %s (cycle %0d)", what, cycle_count);
    endtask

    task automatic report_request_mismatch(input mat_sel_t want_sel, input addr_t want_base,
            input burst_len_t want_len, input mat_sel_t got_sel, input addr_t got_base,
            input burst_len_t got_len);
        protocol_errors++;
        $display("CHECK FAILED request_order expected %b/%h/%0d actual %b/%h/%0d",
            want_sel, want_base, want_len, got_sel, got_base, got_len);
    endtask

    a_req_order: assert property (@(posedge clk) disable iff (!rst)
        req_valid |-> req_sel == exp_sel && req_base == exp_base && req_len == exp_len)
        else report_request_mismatch($sampled(exp_sel), $sampled(exp_base),
            $sampled(exp_len), $sampled(req_sel), $sampled(req_base), $sampled(req_len));
    a_req_hold: assert property (@(posedge clk) disable iff (!rst)
        req_valid && !arready |=> req_valid && $stable(req_sel)
            && $stable(req_base) && $stable(req_len))
        else flag_protocol_error("request changed under back-pressure");
    a_req_drop: assert property (@(posedge clk) disable iff (!rst)
        req_valid && arready |=> !req_valid)
        else flag_protocol_error("request still valid after acceptance");
    a_reset_quiet: assert property (@(posedge clk) !rst |=> !req_valid && !done)
        else flag_protocol_error("request or done high out of reset");
    a_done_hold: assert property (@(posedge clk) disable iff (!rst)
        done && !start |=> done)
        else flag_protocol_error("done dropped without a start");
    a_three_bursts: assert property (@(posedge clk) disable iff (!rst)
        $rose(done) |-> burst_total == 3 * (done_total + 1)
            && req_total == 3 * (done_total + 1))
        else flag_protocol_error("done rose without exactly three bursts");

    function automatic beat_t beat_word(input mat_sel_t sel, input int n);
        beat_t w;
        w = '0;
        for (int k = 0; k < TILE_N; k++) begin
            if (sel == MAT_A) w[k*ELEM_W +: ELEM_W] = mat_a[n % TILE_N][k];
            if (sel == MAT_B) w[k*ELEM_W +: ELEM_W] = mat_b[n % TILE_N][k];
        end
        if (sel == MAT_C) w = mat_c[n / TILE_N][n % TILE_N]; // Row major words
        return w;
    endfunction

    task automatic serve_burst(input mat_sel_t sel, input burst_len_t len);
        int hold;
        int gap;
        hold = int'($unsigned($random(seed)) % 4);
        repeat (hold) @(negedge clk);
        arready = 1'b1;
        @(negedge clk);
        arready = 1'b0;
        for (int n = 0; n <= int'(len); n++) begin
            gap = int'($unsigned($random(seed)) % 3);
            repeat (gap) @(negedge clk);
            beat_valid = 1'b1;
            beat_idx   = beat_idx_t'(n);
            beat_data  = beat_word(sel, n);
            @(negedge clk);
            beat_valid = 1'b0;
        end
        gap = int'($unsigned($random(seed)) % 3);
        repeat (gap) @(negedge clk);
        burst_done = 1'b1;
        @(negedge clk);
        burst_done = 1'b0;
    endtask

    initial begin : responder
        forever begin
            @(negedge clk);
            if (rst && req_valid) serve_burst(req_sel, req_len);
        end
    end

    task automatic load_random_tile();
        for (int r = 0; r < TILE_N; r++) begin
            for (int c = 0; c < TILE_N; c++) begin
                mat_a[r][c] = elem_t'($random(seed));
                mat_b[r][c] = elem_t'($random(seed));
                mat_c[r][c] = $random(seed);
            end
        end
    endtask

    // Sums near the INT32 limits so that the accumulators wrap
    task automatic load_extreme_tile();
        for (int r = 0; r < TILE_N; r++) begin
            for (int c = 0; c < TILE_N; c++) begin
                mat_a[r][c] = ((r + c) % 2 == 0) ? 8'sh80 : 8'sh7f;
                mat_b[r][c] = (r == c) ? 8'sh7f : 8'sh80;
                mat_c[r][c] = ((r + c) % 2 == 0) ? 32'sh8000_0100 : 32'sh7fff_ff00;
            end
        end
    endtask

    task automatic pulse_start();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic run_job(input bit poke);
        int job;
        job = done_total;
        pulse_start();
        if (poke) begin
            while (req_total < 3 * job + 2) @(negedge clk);
            pulse_start(); // Ignored in LOAD_A
            while (burst_total < 3 * job + 3) @(negedge clk);
            pulse_start(); // Ignored in COMPUTE
        end
        while (!done) @(negedge clk);
    endtask

    task automatic check_result(input string name);
        int sum;
        acc_t expected;
        for (int r = 0; r < TILE_N; r++) begin
            for (int c = 0; c < TILE_N; c++) begin
                sum = 0;
                for (int k = 0; k < TILE_N; k++) begin
                    sum += int'(mat_a[r][k]) * int'(mat_b[k][c]);
                end
                expected = mat_c[r][c] + sum;
                rd_row = idx_t'(r);
                rd_col = idx_t'(c);
                @(posedge clk);
                assert (rd_data == expected) else begin
                    result_errors++;
                    $display("CHECK FAILED %s D[%0d][%0d] expected %0d actual %0d",
                        name, r, c, expected, rd_data);
                end
                @(negedge clk);
            end
        end
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("ERROR: no result after %0d cycles", TIMEOUT);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : main
        start      = 1'b0;
        arready    = 1'b0;
        beat_valid = 1'b0;
        beat_idx   = '0;
        beat_data  = '0;
        burst_done = 1'b0;
        rd_row     = '0;
        rd_col     = '0;
        seed       = 32'hb198_2ad5;
        result_errors   = 0;
        protocol_errors = 0;
        wait (rst === 1'b1);
        @(negedge clk);
        load_random_tile();
        run_job(1'b1);
        check_result("random");
        load_extreme_tile();
        run_job(1'b0);
        check_result("extreme");
        load_random_tile();
        run_job(1'b1);
        check_result("restart_from_done");
        $display("errors: result %0d, protocol %0d", result_errors, protocol_errors);
        if (result_errors == 0 && protocol_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: tensor_core.f
hdl/tc_size_pkg.sv
hdl/tc_ctrl_pkg.sv
hdl/tile_sequencer.sv
hdl/beat_unpacker.sv
hdl/operand_buffer.sv
hdl/systolic_array.sv
hdl/tensor_core.sv
dv/tb_clock_gen.sv
dv/tensor_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the tensor core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f tensor_core.f \
        --top-module tensor_core_tb -Mdir obj_dir -o tensor_core_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tensor_core_sim > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error status"
    exit 1
fi
cat sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
